// ==== common/debug_pkg.sv ====
package debug_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;       // One UART byte.
  typedef logic [31:0] word_t;       // MIPS instruction or database word.
  typedef logic [10:0] prog_addr_t;  // Instruction memory word address.

  // Database field driven by the core onto i_database_word.
  typedef enum logic [2:0] {
    DB_IDLE     = 3'd0,  // Nothing selected.
    DB_RUN      = 3'd1,  // Core is executing.
    DB_PC       = 3'd2,  // Program counter.
    DB_CYCLES   = 3'd3,  // Cycle counter.
    DB_ADDER_PC = 3'd4,  // PC + 4 adder output.
    DB_INSTR    = 3'd5   // Fetched instruction.
  } db_sel_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles between the blocks
  ////////////////////////////////////////////////////////////////////////////

  // One byte received from the host.
  typedef struct packed {
    logic  valid;  // One cycle strobe.
    byte_t data;   // Received byte.
  } host_byte_t;

  // One byte handed to the UART transmitter.
  typedef struct packed {
    logic  start;  // One cycle pulse.
    byte_t data;   // Byte to send.
  } tx_byte_t;

  // Instruction memory write port.
  typedef struct packed {
    logic       we;    // Write strobe.
    prog_addr_t addr;  // Word address.
    word_t      data;  // Instruction word.
  } prog_write_t;

  ////////////////////////////////////////////////////////////////////////////
  // Host protocol
  ////////////////////////////////////////////////////////////////////////////

  localparam byte_t CMD_SOFT_RESET = 8'h00;  // Reset the core.
  localparam byte_t CMD_LOAD       = 8'h01;  // Load a program, also the ready byte.
  localparam byte_t CMD_RUN        = 8'h03;  // Continuous execution.
  localparam byte_t CMD_STEP       = 8'h07;  // Step by step execution.

  // Bit of the run command that selects step mode.
  localparam int MODE_BIT = 2;

  // Host acknowledge for report step n is n times this code.
  localparam byte_t REPORT_ACK_UNIT = 8'h08;

  // Bytes sent back after a halt.
  localparam int REPORT_STEPS = 10;

  // The HALT instruction is the all zero word, which also ends a program.
  localparam word_t HALT_WORD = '0;

  localparam int BYTES_PER_WORD = 4;  // Program bytes per instruction.

endpackage

// ==== control/debug_control.sv ====
`timescale 1ns/1ps

module debug_control import debug_pkg::*; (
  input  logic       i_clock,
  input  logic       i_reset,
  input  logic       i_rx_done,
  input  byte_t      i_rx_data,
  input  logic       i_soft_reset_ack,
  input  word_t      i_fetch_word,
  input  logic       i_load_done,
  input  tx_byte_t   i_report_tx,
  input  db_sel_t    i_report_db_sel,
  input  logic       i_report_done,
  output host_byte_t o_host_byte,
  output logic       o_load_enable,
  output logic       o_report_enable,
  output logic       o_tx_start,
  output byte_t      o_tx_data,
  output logic       o_soft_reset_req,
  output logic       o_step_mode,
  output logic       o_pc_enable,
  output db_sel_t    o_db_sel
);

  typedef enum logic [2:0] {
    ST_IDLE,           // Wait for a soft reset command.
    ST_RESET_REQ,      // Req high, wait for ack.
    ST_RESET_RELEASE,  // Req low, wait for ack to drop.
    ST_READY,          // Ready byte sent, wait for CMD_LOAD.
    ST_LOAD,           // Program loader owns the host bytes.
    ST_START_WAIT,     // Wait for run or step.
    ST_RUN,            // Core executes until HALT.
    ST_REPORT          // Report sequencer owns the link.
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   rx_done_q;
  logic   host_valid_q;
  byte_t  host_data_q;
  logic   mode_q;         // Step mode of the current run.
  logic   ready_start_q;  // Ready byte pulse.
  logic   run_cmd;

  ////////////////////////////////////////////////////////////////////////////
  // Host byte detection
  ////////////////////////////////////////////////////////////////////////////

  // The receiver drops rx_done once the byte is complete.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      rx_done_q    <= 1'b0;
      host_valid_q <= 1'b0;
    end else begin
      rx_done_q    <= i_rx_done;
      host_valid_q <= rx_done_q & ~i_rx_done;  // Falling edge.
    end
  end

  always_ff @(posedge i_clock) begin
    host_data_q <= i_rx_data;
  end

  assign o_host_byte = '{valid: host_valid_q, data: host_data_q};

  assign run_cmd = host_valid_q && (host_data_q == CMD_RUN || host_data_q == CMD_STEP);

  ////////////////////////////////////////////////////////////////////////////
  // Main FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (host_valid_q && host_data_q == CMD_SOFT_RESET) begin
          state_d = ST_RESET_REQ;
        end
      end
      ST_RESET_REQ: begin
        if (i_soft_reset_ack) begin
          state_d = ST_RESET_RELEASE;
        end
      end
      ST_RESET_RELEASE: begin
        if (!i_soft_reset_ack) begin
          state_d = ST_READY;
        end
      end
      ST_READY: begin
        if (host_valid_q && host_data_q == CMD_LOAD) begin
          state_d = ST_LOAD;
        end
      end
      ST_LOAD: begin
        if (i_load_done) begin
          state_d = ST_START_WAIT;
        end
      end
      ST_START_WAIT: begin
        if (run_cmd) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        if (i_fetch_word == HALT_WORD) begin
          state_d = ST_REPORT;
        end
      end
      ST_REPORT: begin
        if (i_report_done) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state_q       <= ST_IDLE;
      mode_q        <= 1'b0;
      ready_start_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      ready_start_q <= (state_q == ST_RESET_RELEASE) && !i_soft_reset_ack;
      if (state_q == ST_START_WAIT && run_cmd) begin
        mode_q <= host_data_q[MODE_BIT];  // Step when set.
      end else if (state_q == ST_REPORT && i_report_done) begin
        mode_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign o_soft_reset_req = (state_q == ST_RESET_REQ);
  assign o_load_enable    = (state_q == ST_LOAD);
  assign o_report_enable  = (state_q == ST_REPORT);
  assign o_pc_enable      = (state_q == ST_RUN);
  assign o_step_mode      = mode_q;

  // The sequencer owns the transmitter while reporting.
  assign o_tx_start = o_report_enable ? i_report_tx.start : ready_start_q;
  assign o_tx_data  = o_report_enable ? i_report_tx.data : CMD_LOAD;

  always_comb begin
    case (state_q)
      ST_RUN:    o_db_sel = DB_RUN;
      ST_REPORT: o_db_sel = i_report_db_sel;
      default:   o_db_sel = DB_IDLE;
    endcase
  end

  // Req only drops once the core has answered.
  a_req_drop_after_ack: assert property (@(posedge i_clock) disable iff (!i_reset)
    $fell(o_soft_reset_req) |-> $past(i_soft_reset_ack));

  // The run only ends on a fetched HALT.
  a_run_ends_on_halt: assert property (@(posedge i_clock) disable iff (!i_reset)
    $fell(o_pc_enable) |-> $past(i_fetch_word) == HALT_WORD);

endmodule

// ==== loader/program_loader.sv ====
`timescale 1ns/1ps

module program_loader import debug_pkg::*; (
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic        i_enable,
  input  host_byte_t  i_host_byte,
  output prog_write_t o_prog_write,
  output logic        o_load_done
);

  logic [1:0] byte_cnt_q;  // Bytes of the current word so far.
  prog_addr_t addr_q;      // Next free word address.
  word_t      word_q;      // Partial word, MSB first.
  word_t      word_next;
  logic       word_full;
  logic       we_q;
  logic       done_q;
  prog_addr_t wr_addr_q;
  word_t      wr_data_q;

  // Shift the new byte in at the low end.
  assign word_next = {word_q[23:0], i_host_byte.data};
  assign word_full = i_host_byte.valid && (byte_cnt_q == 2'(BYTES_PER_WORD - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Byte assembly and write control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset || !i_enable) begin
      byte_cnt_q <= '0;
      addr_q     <= '0;
      word_q     <= '0;
      we_q       <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      we_q   <= 1'b0;
      done_q <= 1'b0;
      if (i_host_byte.valid) begin
        word_q     <= word_next;
        byte_cnt_q <= byte_cnt_q + 2'd1;  // Wraps every word.
      end
      if (word_full) begin
        if (word_next == HALT_WORD) begin
          done_q <= 1'b1;  // End of program.
        end else begin
          we_q   <= 1'b1;
          addr_q <= addr_q + prog_addr_t'(1);
        end
      end
    end
  end

  // Write payload follows the strobe.
  always_ff @(posedge i_clock) begin
    if (word_full) begin
      wr_addr_q <= addr_q;
      wr_data_q <= word_next;
    end
  end

  assign o_prog_write = '{we: we_q, addr: wr_addr_q, data: wr_data_q};
  assign o_load_done  = done_q;

  // The controller must hold the loader enabled until every write is out.
  a_we_while_enabled: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_prog_write.we |-> i_enable);

endmodule

// ==== report/report_sequencer.sv ====
`timescale 1ns/1ps

module report_sequencer import debug_pkg::*; (
  input  logic       i_clock,
  input  logic       i_reset,
  input  logic       i_enable,
  input  host_byte_t i_host_byte,
  input  word_t      i_database_word,
  output tx_byte_t   o_tx,
  output db_sel_t    o_db_sel,
  output logic       o_done
);

  logic [3:0] step_q;     // Current step, 1 to REPORT_STEPS.
  logic       armed_q;    // Step entered, byte not yet sent.
  logic       start_q;
  logic       done_q;
  byte_t      tx_data_q;
  db_sel_t    field_sel;
  logic [1:0] lane;       // Byte lane of the database word.
  byte_t      ack_code;
  logic       ack_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Field and byte lane per step
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (step_q)
      4'd1:    begin field_sel = DB_PC;       lane = 2'd1; end
      4'd2:    begin field_sel = DB_PC;       lane = 2'd0; end
      4'd3:    begin field_sel = DB_CYCLES;   lane = 2'd1; end
      4'd4:    begin field_sel = DB_CYCLES;   lane = 2'd0; end
      4'd5:    begin field_sel = DB_ADDER_PC; lane = 2'd1; end
      4'd6:    begin field_sel = DB_ADDER_PC; lane = 2'd0; end
      4'd7:    begin field_sel = DB_INSTR;    lane = 2'd3; end
      4'd8:    begin field_sel = DB_INSTR;    lane = 2'd2; end
      4'd9:    begin field_sel = DB_INSTR;    lane = 2'd1; end
      4'd10:   begin field_sel = DB_INSTR;    lane = 2'd0; end
      default: begin field_sel = DB_IDLE;     lane = 2'd0; end
    endcase
  end

  // Host answers step n with n * REPORT_ACK_UNIT.
  assign ack_code = {4'd0, step_q} * REPORT_ACK_UNIT;
  assign ack_hit  = i_host_byte.valid && (i_host_byte.data == ack_code) && !done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Step counter and transmit pulse
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset || !i_enable) begin
      step_q  <= 4'd1;
      armed_q <= 1'b1;  // First byte goes out once enabled.
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= armed_q;
      armed_q <= 1'b0;
      done_q  <= 1'b0;
      if (ack_hit) begin
        if (step_q == 4'(REPORT_STEPS)) begin
          done_q <= 1'b1;
        end else begin
          step_q  <= step_q + 4'd1;
          armed_q <= 1'b1;
        end
      end
    end
  end

  // Database word is valid for the selected field in the armed cycle.
  always_ff @(posedge i_clock) begin
    if (armed_q) begin
      tx_data_q <= i_database_word[{lane, 3'b000} +: 8];
    end
  end

  assign o_tx     = '{start: start_q, data: tx_data_q};
  assign o_db_sel = i_enable ? field_sel : DB_IDLE;
  assign o_done   = done_q;

  // A byte is only sent while the core is driving a report field.
  a_tx_with_field: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_tx.start |-> o_db_sel != DB_IDLE);

endmodule

// ==== verilog/debug_unit.sv ====
`timescale 1ns/1ps

module debug_unit import debug_pkg::*; (
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic        i_rx_done,
  input  byte_t       i_rx_data,
  input  logic        i_soft_reset_ack,
  input  word_t       i_fetch_word,
  input  word_t       i_database_word,
  output logic        o_tx_start,
  output byte_t       o_tx_data,
  output logic        o_soft_reset_req,
  output prog_write_t o_prog_write,
  output logic        o_step_mode,
  output logic        o_pc_enable,
  output db_sel_t     o_db_sel
);

  host_byte_t host_byte;    // Registered host strobe, shared.
  logic       load_enable;
  logic       load_done;
  logic       report_enable;
  tx_byte_t   report_tx;
  db_sel_t    report_db_sel;
  logic       report_done;

  debug_control debug_control_inst (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_done        (i_rx_done),
    .i_rx_data        (i_rx_data),
    .i_soft_reset_ack (i_soft_reset_ack),
    .i_fetch_word     (i_fetch_word),
    .i_load_done      (load_done),
    .i_report_tx      (report_tx),
    .i_report_db_sel  (report_db_sel),
    .i_report_done    (report_done),
    .o_host_byte      (host_byte),
    .o_load_enable    (load_enable),
    .o_report_enable  (report_enable),
    .o_tx_start       (o_tx_start),
    .o_tx_data        (o_tx_data),
    .o_soft_reset_req (o_soft_reset_req),
    .o_step_mode      (o_step_mode),
    .o_pc_enable      (o_pc_enable),
    .o_db_sel         (o_db_sel)
  );

  program_loader program_loader_inst (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_enable    (load_enable),
    .i_host_byte (host_byte),
    .o_prog_write(o_prog_write),
    .o_load_done (load_done)
  );

  report_sequencer report_sequencer_inst (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_enable        (report_enable),
    .i_host_byte     (host_byte),
    .i_database_word (i_database_word),
    .o_tx            (report_tx),
    .o_db_sel        (report_db_sel),
    .o_done          (report_done)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clock,
  output logic o_reset
);

  initial begin
    o_clock = 1'b0;
    forever begin
      #4 o_clock = ~o_clock;  // 8 ns period.
    end
  end

  // Active low reset for the first 16 cycles.
  initial begin
    o_reset = 1'b0;
    repeat (16) @(posedge o_clock);
    #1 o_reset = 1'b1;
  end

endmodule

// ==== test/debug_unit_tb.sv ====
`timescale 1ns/1ps

module debug_unit_tb import debug_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 200;

  logic        i_clock;
  logic        i_reset;
  logic        i_rx_done;
  byte_t       i_rx_data;
  logic        i_soft_reset_ack = 1'b0;
  word_t       i_fetch_word;
  word_t       i_database_word;
  logic        o_tx_start;
  byte_t       o_tx_data;
  logic        o_soft_reset_req;
  prog_write_t o_prog_write;
  logic        o_step_mode;
  logic        o_pc_enable;
  db_sel_t     o_db_sel;

  integer     seed;
  int         error_count;
  int         waited;
  int         ack_delay = 0;
  word_t      exp_words [10];   // Words sent in both loads.
  logic [3:0] word_base;        // First write index of the current load.
  logic [3:0] write_count;
  logic [4:0] report_count;     // Report bytes seen over both runs.
  logic [1:0] ready_count;
  logic       exp_step_mode;

  tb_clock_gen tb_clock_gen_inst (.o_clock(i_clock), .o_reset(i_reset));

  debug_unit debug_unit_inst (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Core model
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (o_db_sel)
      DB_PC:       i_database_word = 32'h0000_1234;
      DB_CYCLES:   i_database_word = 32'h0000_ABCD;
      DB_ADDER_PC: i_database_word = 32'h0000_5678;
      DB_INSTR:    i_database_word = 32'hDEAD_BEEF;
      default:     i_database_word = 32'h0;
    endcase
  end

  // Ack follows req after three cycles in both directions.
  always @(posedge i_clock) begin
    #1;
    if (!i_reset || o_soft_reset_req == i_soft_reset_ack) begin
      ack_delay = 0;
    end else if (ack_delay == 2) begin
      i_soft_reset_ack = o_soft_reset_req;
      ack_delay = 0;
    end else begin
      ack_delay = ack_delay + 1;
    end
  end

  always @(posedge i_clock) begin
    if (!i_reset) begin
      write_count  <= '0;
      report_count <= '0;
      ready_count  <= '0;
    end else begin
      if (o_prog_write.we) write_count <= write_count + 4'd1;
      if (o_tx_start && o_db_sel != DB_IDLE) report_count <= report_count + 5'd1;
      if (o_tx_start && o_db_sel == DB_IDLE) ready_count <= ready_count + 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    error_count = error_count + 1;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("checks failed: %0d, timeouts: 1", error_count);
    $display("FAIL: see errors above");
    $finish;
  endtask

  // Byte n of the report from the core model values and the lane order.
  function automatic byte_t expected_report_byte(input logic [4:0] count);
    logic [4:0] idx;
    idx = (count >= 5'd10) ? count - 5'd10 : count;
    case (idx)
      5'd0:    return 8'h12;
      5'd1:    return 8'h34;
      5'd2:    return 8'hAB;
      5'd3:    return 8'hCD;
      5'd4:    return 8'h56;
      5'd5:    return 8'h78;
      5'd6:    return 8'hDE;
      5'd7:    return 8'hAD;
      5'd8:    return 8'hBE;
      default: return 8'hEF;
    endcase
  endfunction

  // The strobe appears one cycle after rx_done falls.
  task automatic send_host_byte(input byte_t value);
    @(posedge i_clock);
    #1 i_rx_data = value;
    i_rx_done = 1'b1;
    @(posedge i_clock);
    #1 i_rx_done = 1'b0;
    repeat (2) @(posedge i_clock);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge i_clock) $rose(i_reset) |->
    !o_soft_reset_req && !o_tx_start && !o_prog_write.we && !o_pc_enable &&
    !o_step_mode && o_db_sel == DB_IDLE)
    else report_mismatch("reset_idle", 32'h0,
                         32'({$sampled(o_soft_reset_req), $sampled(o_tx_start),
                              $sampled(o_prog_write.we), $sampled(o_pc_enable),
                              $sampled(o_step_mode), $sampled(o_db_sel)}));

  a_req_drop: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_soft_reset_req && i_soft_reset_ack |=> !o_soft_reset_req)
    else report_mismatch("req_drop", 32'h0, 32'($sampled(o_soft_reset_req)));

  a_req_fall_after_ack: assert property (@(posedge i_clock) disable iff (!i_reset)
    $fell(o_soft_reset_req) |-> $past(i_soft_reset_ack))
    else report_mismatch("req_fall_after_ack", 32'h1, 32'h0);

  a_ready_byte: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_tx_start && o_db_sel == DB_IDLE |-> o_tx_data == CMD_LOAD && !i_soft_reset_ack)
    else report_mismatch("ready_byte", 32'(CMD_LOAD), 32'($sampled(o_tx_data)));

  a_write: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_prog_write.we |-> o_prog_write.addr == prog_addr_t'(write_count - word_base) &&
    o_prog_write.data == exp_words[write_count])
    else report_mismatch("prog_write", exp_words[$sampled(write_count)],
                         $sampled(o_prog_write.data));

  a_run_outputs: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_pc_enable |-> o_db_sel == DB_RUN && o_step_mode == exp_step_mode)
    else report_mismatch("run_outputs", 32'({exp_step_mode, 3'(DB_RUN)}),
                         32'({$sampled(o_step_mode), $sampled(o_db_sel)}));

  a_halt: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_pc_enable && i_fetch_word == HALT_WORD |=> !o_pc_enable)
    else report_mismatch("halt", 32'h0, 32'($sampled(o_pc_enable)));

  a_report_byte: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_tx_start && o_db_sel != DB_IDLE |-> o_tx_data == expected_report_byte(report_count))
    else report_mismatch("report_byte", 32'(expected_report_byte($sampled(report_count))),
                         32'($sampled(o_tx_data)));

  a_single_pulse: assert property (@(posedge i_clock) disable iff (!i_reset)
    o_tx_start |=> !o_tx_start)
    else report_mismatch("single_pulse", 32'h0, 32'($sampled(o_tx_start)));

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_sequence(input byte_t run_code, input logic [3:0] base);
    logic [4:0] target;
    word_base = base;
    exp_step_mode = (run_code == CMD_STEP);
    send_host_byte(CMD_SOFT_RESET);
    waited = 0;
    while (!o_soft_reset_req) begin
      if (waited == TIMEOUT_CYCLES) abort_on_timeout("soft reset request");
      @(posedge i_clock);
      waited = waited + 1;
    end
    waited = 0;
    while (ready_count != 2'(base / 5 + 1)) begin  // One ready byte per sequence.
      if (waited == TIMEOUT_CYCLES) abort_on_timeout("ready byte");
      @(posedge i_clock);
      waited = waited + 1;
    end
    send_host_byte(CMD_LOAD);
    for (int w = 0; w < 5; w++) begin
      exp_words[base + 4'(w)] = $random(seed);
      if (exp_words[base + 4'(w)] == HALT_WORD) exp_words[base + 4'(w)] = 32'h1;
      for (int b = 3; b >= 0; b--) send_host_byte(exp_words[base + 4'(w)][8*b +: 8]);
    end
    for (int b = 0; b < 4; b++) send_host_byte(8'h00);
    #1 i_fetch_word = 32'h2108_0001;
    send_host_byte(run_code);
    a_load_count: assert (write_count == base + 4'd5)
      else report_mismatch("load_count", 32'(base + 4'd5), 32'(write_count));
    a_ready_once: assert (ready_count == 2'(base / 5 + 1))
      else report_mismatch("ready_once", 32'(base / 5 + 1), 32'(ready_count));
    waited = 0;
    while (!o_pc_enable) begin
      if (waited == TIMEOUT_CYCLES) abort_on_timeout("pc enable");
      @(posedge i_clock);
      waited = waited + 1;
    end
    repeat (5) @(posedge i_clock);
    #1 i_fetch_word = HALT_WORD;
    for (int n = 1; n <= REPORT_STEPS; n++) begin
      target = 5'(base) * 5'd2 + 5'(n);
      waited = 0;
      while (report_count != target) begin
        if (waited == TIMEOUT_CYCLES) abort_on_timeout("report byte");
        @(posedge i_clock);
        waited = waited + 1;
      end
      if (n == 3) begin
        send_host_byte(8'h55);  // Not an acknowledge code.
        repeat (6) @(posedge i_clock);
        a_wrong_ack: assert (report_count == target)
          else report_mismatch("wrong_ack", 32'(target), 32'(report_count));
      end
      send_host_byte(byte_t'(n) * REPORT_ACK_UNIT);
    end
    waited = 0;
    while (o_db_sel != DB_IDLE) begin
      if (waited == TIMEOUT_CYCLES) abort_on_timeout("report end");
      @(posedge i_clock);
      waited = waited + 1;
    end
    #1 i_fetch_word = 32'h2108_0001;
  endtask

  initial begin
    seed = 19039;
    error_count = 0;
    i_rx_done = 1'b0;
    i_rx_data = '0;
    i_fetch_word = 32'h2108_0001;
    word_base = '0;
    exp_step_mode = 1'b0;
    waited = 0;
    while (!i_reset) begin
      if (waited == TIMEOUT_CYCLES) abort_on_timeout("reset release");
      @(posedge i_clock);
      waited = waited + 1;
    end
    repeat (2) @(posedge i_clock);
    run_sequence(CMD_STEP, 4'd0);
    run_sequence(CMD_RUN, 4'd5);
    a_report_total: assert (report_count == 5'd20)
      else report_mismatch("report_total", 32'd20, 32'(report_count));
    $display("checks failed: %0d, timeouts: 0", error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
common/debug_pkg.sv
control/debug_control.sv
loader/program_loader.sv
report/report_sequencer.sv
verilog/debug_unit.sv
test/tb_clock_gen.sv
test/debug_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the debug unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
  --top-module debug_unit_tb \
  --Mdir "$BUILD_DIR" -o sim \
  -f tb.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
